//--- source/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// word-address widths, one 32-bit word per entry
`define MMU_INST_AW 12
`define MMU_DATA_AW 12

`define MMU_INST_DEPTH (1 << `MMU_INST_AW)
`define MMU_DATA_DEPTH (1 << `MMU_DATA_AW)

// address bit that splits data memory into regions 8 and 9
`define MMU_DATA_BANK_BIT 20

`endif

//--- source/bus_pkg.sv
`default_nettype none

package bus_pkg;

  ////////////////////////////////////////
  // data-path types
  ////////////////////////////////////////

  typedef logic [31:0] word_t;     // cpu data word
  typedef logic [7:0]  byte_t;     // uart payload and byte lanes
  typedef logic [3:0]  byte_en_t;  // one enable per lane, lane 0 = bits 7:0

  // spu line of four words
  // packed so that word 0 (lowest address) lands in bits 31:0
  typedef word_t [3:0] spu_line_t;

endpackage

`default_nettype wire

//--- source/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  ////////////////////////////////////////
  // region decode, cpu address bits 23:20
  ////////////////////////////////////////

  localparam int REGION_LSB = 20;
  localparam int REGION_MSB = 23;

  typedef enum logic [3:0] {
    REG_INST    = 4'h0,  // instruction memory
    REG_DATA_LO = 4'h8,  // data memory, lower bank
    REG_DATA_HI = 4'h9,  // data memory, upper bank
    REG_UART    = 4'hA,  // serial port registers
    REG_RESULT  = 4'hB   // spu results and cycle counter
  } region_e;

  ////////////////////////////////////////
  // register offsets within a region
  ////////////////////////////////////////

  // uart
  localparam logic [7:0] UART_TX_OFS      = 8'h00;  // write only
  localparam logic [7:0] UART_TXFULL_OFS  = 8'h04;
  localparam logic [7:0] UART_RXEMPTY_OFS = 8'h08;
  localparam logic [7:0] UART_RXDATA_OFS  = 8'h0C;  // read pops the rx byte

  // counter halves, result registers sit at 0x00..0x3C
  localparam logic [7:0] CNT_LO_OFS = 8'h40;
  localparam logic [7:0] CNT_HI_OFS = 8'h44;

endpackage

`default_nettype wire

//--- source/periph_if.sv
`timescale 1ns/10ps
`default_nettype none

// one register access, router to peripheral
interface periph_if;
  import bus_pkg::*;

  logic       sel;     // access accepted this cycle
  logic       write;
  logic [7:0] offset;  // byte offset inside the region
  word_t      wdata;
  word_t      rdata;   // registered, valid the cycle after sel
  logic       busy;    // holds off tx writes

  modport host (
    output sel, write, offset, wdata,
    input  rdata, busy
  );

  modport dev (
    input  sel, write, offset, wdata,
    output rdata, busy
  );

endinterface

`default_nettype wire

//--- source/inst_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cfg.svh"

module inst_mem (
  input  logic                    clk,
  input  bus_pkg::word_t          pc,
  output bus_pkg::word_t          instr,
  input  logic                    we,
  input  logic [`MMU_INST_AW-1:0] addr,
  input  bus_pkg::word_t          wdata,
  output bus_pkg::word_t          rdata
);
  import bus_pkg::*;

  word_t                   mem [`MMU_INST_DEPTH];
  logic [`MMU_INST_AW-1:0] fetch_idx;

  assign fetch_idx = pc[`MMU_INST_AW+1:2];  // pc is byte addressed

  ////////////////////////////////////////
  // fetch port, read only
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    instr <= mem[fetch_idx];
  end

  ////////////////////////////////////////
  // cpu port, whole words
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;  // program load
    end
    rdata <= mem[addr];    // old data on same-cycle write
  end

endmodule

`default_nettype wire

//--- source/data_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cfg.svh"

module data_mem (
  input  logic                    clk,
  input  bus_pkg::byte_en_t       be,
  input  logic [`MMU_DATA_AW-1:0] addr,
  input  bus_pkg::word_t          wdata,
  output bus_pkg::word_t          rdata,
  input  bus_pkg::word_t          spu_addr,
  output bus_pkg::spu_line_t      spu_rdata
);
  import bus_pkg::*;

  word_t                   mem [`MMU_DATA_DEPTH];
  logic [`MMU_DATA_AW-3:0] line_idx;

  // same bank split as the cpu side, then drop the word-in-line bits
  assign line_idx = {spu_addr[`MMU_DATA_BANK_BIT], spu_addr[`MMU_DATA_AW:4]};

  ////////////////////////////////////////
  // cpu port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];  // lane b only
      end
    end
    rdata <= mem[addr];
  end

  ////////////////////////////////////////
  // spu line port, 16 byte aligned
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int w = 0; w < 4; w++) begin
      spu_rdata[w] <= mem[{line_idx, 2'(w)}];  // word 0 in the low bits
    end
  end

endmodule

`default_nettype wire

//--- source/result_regs.sv
`timescale 1ns/10ps
`default_nettype none

module result_regs (
  input  logic           clk,
  input  logic           rst,
  periph_if.dev          bus,
  input  logic           spu_res_we,
  input  logic [3:0]     spu_res_addr,
  input  bus_pkg::word_t spu_res_data,
  output bus_pkg::word_t disp_0,
  output bus_pkg::word_t disp_1,
  output bus_pkg::word_t disp_2
);
  import bus_pkg::*;
  import mem_map_pkg::*;

  word_t       res_q [16];
  logic [63:0] cnt_q;
  logic        rd_en;
  logic        cnt_clr;

  assign bus.busy = 1'b0;  // cpu writes here never stall
  assign rd_en    = bus.sel && !bus.write;
  assign cnt_clr  = bus.sel && bus.write &&
                    (bus.offset == CNT_LO_OFS || bus.offset == CNT_HI_OFS);

  // display words
  assign disp_0 = res_q[0];
  assign disp_1 = res_q[1];
  assign disp_2 = res_q[2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        res_q[i] <= '0;
      end
    end else if (spu_res_we) begin
      res_q[spu_res_addr] <= spu_res_data;
    end
  end

  // free-running cycle counter, cleared by any cpu write to either half
  always_ff @(posedge clk) begin
    if (rst || cnt_clr) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (bus.offset[7:6] == 2'b00) begin
        bus.rdata <= res_q[bus.offset[5:2]];  // pre-write value on a collision
      end else if (bus.offset == CNT_LO_OFS) begin
        bus.rdata <= cnt_q[31:0];
      end else if (bus.offset == CNT_HI_OFS) begin
        bus.rdata <= cnt_q[63:32];
      end else begin
        bus.rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/uart_port.sv
`timescale 1ns/10ps
`default_nettype none

module uart_port (
  input  logic           clk,
  input  logic           rst,
  periph_if.dev          bus,
  input  logic           uart_tx_full,
  input  logic           uart_rx_empty,
  input  bus_pkg::byte_t uart_rx_data,
  output bus_pkg::byte_t uart_tx_data,
  output logic           uart_trmt,
  output logic           uart_rd
);
  import mem_map_pkg::*;

  logic rd_en;

  assign rd_en    = bus.sel && !bus.write;
  assign bus.busy = uart_tx_full;  // router holds tx writes while set

  ////////////////////////////////////////
  // strobes toward the uart
  ////////////////////////////////////////

  assign uart_trmt    = bus.sel && bus.write && (bus.offset == UART_TX_OFS);
  assign uart_tx_data = bus.wdata[7:0];
  assign uart_rd      = rd_en && (bus.offset == UART_RXDATA_OFS);  // pop

  // status and rx byte, sampled at the accepting edge
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.rdata <= '0;
    end else if (rd_en) begin
      case (bus.offset)
        UART_TXFULL_OFS:  bus.rdata <= {31'd0, uart_tx_full};
        UART_RXEMPTY_OFS: bus.rdata <= {31'd0, uart_rx_empty};
        UART_RXDATA_OFS:  bus.rdata <= {24'd0, uart_rx_data};
        default:          bus.rdata <= '0;  // tx reads back zero
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/mem_router.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cfg.svh"

module mem_router (
  input  logic                    clk,
  input  logic                    rst,
  // cpu request
  input  logic                    req_valid,
  output logic                    req_ready,
  input  logic                    req_write,
  input  logic                    req_byte,
  input  bus_pkg::word_t          req_addr,
  input  bus_pkg::word_t          req_wdata,
  // cpu response
  output logic                    rsp_valid,
  output bus_pkg::word_t          rsp_rdata,
  output logic                    rsp_fault,
  // instruction memory, data port
  output logic                    imem_we,
  output logic [`MMU_INST_AW-1:0] imem_addr,
  output bus_pkg::word_t          imem_wdata,
  input  bus_pkg::word_t          imem_rdata,
  // data memory, cpu port
  output bus_pkg::byte_en_t       dmem_be,
  output logic [`MMU_DATA_AW-1:0] dmem_addr,
  output bus_pkg::word_t          dmem_wdata,
  input  bus_pkg::word_t          dmem_rdata,
  // peripherals
  periph_if.host                  uart_bus,
  periph_if.host                  res_bus
);
  import bus_pkg::*;
  import mem_map_pkg::*;

  region_e    region;
  logic [1:0] lane;
  logic       is_inst;
  logic       is_data;
  logic       is_uart;
  logic       is_res;
  logic       tx_write;
  logic       accept;
  logic       rd_accept;
  word_t      lane_wdata;
  byte_en_t   lane_be;

  region_e    rd_region_q;
  logic       rd_byte_q;
  logic [1:0] rd_lane_q;
  word_t      rd_word;

  ////////////////////////////////////////
  // decode and handshake
  ////////////////////////////////////////

  assign region  = region_e'(req_addr[REGION_MSB:REGION_LSB]);
  assign lane    = req_addr[1:0];
  assign is_inst = (region == REG_INST);
  assign is_data = (region == REG_DATA_LO) || (region == REG_DATA_HI);
  assign is_uart = (region == REG_UART);
  assign is_res  = (region == REG_RESULT);

  assign tx_write  = is_uart && req_write && (req_addr[7:0] == UART_TX_OFS);
  assign req_ready = !(tx_write && uart_bus.busy);
  assign accept    = req_valid && req_ready;
  assign rd_accept = accept && !req_write;

  ////////////////////////////////////////
  // write path
  ////////////////////////////////////////

  // byte goes to its own lane, word writes all four
  assign lane_wdata = req_byte ? (word_t'(req_wdata[7:0]) << {lane, 3'b000}) : req_wdata;
  assign lane_be    = req_byte ? byte_en_t'(4'b0001 << lane) : 4'b1111;

  assign imem_we    = accept && req_write && is_inst && !req_byte;  // whole words only
  assign imem_addr  = req_addr[`MMU_INST_AW+1:2];
  assign imem_wdata = req_wdata;

  assign dmem_be    = (accept && req_write && is_data) ? lane_be : 4'b0000;
  assign dmem_addr  = {req_addr[`MMU_DATA_BANK_BIT], req_addr[`MMU_DATA_AW:2]};
  assign dmem_wdata = lane_wdata;

  assign uart_bus.sel    = accept && is_uart;
  assign uart_bus.write  = req_write;
  assign uart_bus.offset = req_addr[7:0];
  assign uart_bus.wdata  = req_wdata;  // tx takes the low byte as is

  assign res_bus.sel    = accept && is_res;
  assign res_bus.write  = req_write;
  assign res_bus.offset = req_addr[7:0];
  assign res_bus.wdata  = req_wdata;

  ////////////////////////////////////////
  // read response, one cycle later
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      rsp_fault <= 1'b0;
    end else begin
      rsp_valid <= rd_accept;
      rsp_fault <= rd_accept && !(is_inst || is_data || is_uart || is_res);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_region_q <= region;
      rd_byte_q   <= req_byte;
      rd_lane_q   <= lane;
    end
  end

  always_comb begin
    case (rd_region_q)
      REG_INST:                 rd_word = imem_rdata;
      REG_DATA_LO, REG_DATA_HI: rd_word = dmem_rdata;
      REG_UART:                 rd_word = uart_bus.rdata;
      REG_RESULT:               rd_word = res_bus.rdata;
      default:                  rd_word = '0;  // unmapped reads return zero
    endcase
  end

  // zero-extended lane for byte reads
  assign rsp_rdata = rd_byte_q ? word_t'(rd_word[{rd_lane_q, 3'b000} +: 8]) : rd_word;

endmodule

`default_nettype wire

//--- source/mmu_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cfg.svh"

module mmu_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  output logic                req_ready,
  input  logic                req_write,
  input  logic                req_byte,
  input  bus_pkg::word_t      req_addr,
  input  bus_pkg::word_t      req_wdata,
  output logic                rsp_valid,
  output bus_pkg::word_t      rsp_rdata,
  output logic                rsp_fault,
  input  bus_pkg::word_t      pc,
  output bus_pkg::word_t      instr,
  input  bus_pkg::word_t      spu_addr,
  output bus_pkg::spu_line_t  spu_rdata,
  input  logic                spu_res_we,
  input  logic [3:0]          spu_res_addr,
  input  bus_pkg::word_t      spu_res_data,
  output bus_pkg::word_t      disp_0,
  output bus_pkg::word_t      disp_1,
  output bus_pkg::word_t      disp_2,
  input  logic                uart_tx_full,
  input  logic                uart_rx_empty,
  input  bus_pkg::byte_t      uart_rx_data,
  output bus_pkg::byte_t      uart_tx_data,
  output logic                uart_trmt,
  output logic                uart_rd
);
  import bus_pkg::*;

  logic                    imem_we;
  logic [`MMU_INST_AW-1:0] imem_addr;
  word_t                   imem_wdata;
  word_t                   imem_rdata;
  byte_en_t                dmem_be;
  logic [`MMU_DATA_AW-1:0] dmem_addr;
  word_t                   dmem_wdata;
  word_t                   dmem_rdata;

  periph_if uart_bus ();
  periph_if res_bus ();

  mem_router mem_router_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_write  (req_write),
    .req_byte   (req_byte),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .rsp_fault  (rsp_fault),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .imem_rdata (imem_rdata),
    .dmem_be    (dmem_be),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .uart_bus   (uart_bus.host),
    .res_bus    (res_bus.host)
  );

  inst_mem inst_mem_i (
    .clk   (clk),
    .pc    (pc),
    .instr (instr),
    .we    (imem_we),
    .addr  (imem_addr),
    .wdata (imem_wdata),
    .rdata (imem_rdata)
  );

  data_mem data_mem_i (
    .clk       (clk),
    .be        (dmem_be),
    .addr      (dmem_addr),
    .wdata     (dmem_wdata),
    .rdata     (dmem_rdata),
    .spu_addr  (spu_addr),
    .spu_rdata (spu_rdata)
  );

  result_regs result_regs_i (
    .clk          (clk),
    .rst          (rst),
    .bus          (res_bus.dev),
    .spu_res_we   (spu_res_we),
    .spu_res_addr (spu_res_addr),
    .spu_res_data (spu_res_data),
    .disp_0       (disp_0),
    .disp_1       (disp_1),
    .disp_2       (disp_2)
  );

  uart_port uart_port_i (
    .clk           (clk),
    .rst           (rst),
    .bus           (uart_bus.dev),
    .uart_tx_full  (uart_tx_full),
    .uart_rx_empty (uart_rx_empty),
    .uart_rx_data  (uart_rx_data),
    .uart_tx_data  (uart_tx_data),
    .uart_trmt     (uart_trmt),
    .uart_rd       (uart_rd)
  );

endmodule

`default_nettype wire

//--- sim/mmu_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mmu_cfg.svh"

module mmu_tb;
  import bus_pkg::*;
  import mem_map_pkg::*;

  localparam int TEST_CYCLES = 120 + 20 + 20 + 60 + 60 + 60;  // per-test estimates
  localparam int ACCEPT_LIMIT = 100;

  logic clk, rst;
  logic req_valid, req_ready, req_write, req_byte;
  word_t req_addr, req_wdata;
  logic rsp_valid, rsp_fault;
  word_t rsp_rdata, pc, instr, spu_addr, spu_res_data;
  spu_line_t spu_rdata;
  logic spu_res_we;
  logic [3:0] spu_res_addr;
  word_t disp_0, disp_1, disp_2;
  logic uart_tx_full, uart_rx_empty, uart_trmt, uart_rd;
  byte_t uart_rx_data, uart_tx_data;

  word_t dmem_m [int];  // keyed by word-aligned address
  word_t imem_m [int];
  word_t res_m [int];
  word_t exp_rdata;
  logic exp_fault;
  string test_name;
  int errors, tests_run, tests_failed, err_at_start;
  int cyc, acc_cyc;

  logic rd_acc, exp_trmt, exp_rd;

  mmu_top mmu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////

  assign rd_acc   = req_valid && req_ready && !req_write;
  assign exp_trmt = req_valid && req_write && !uart_tx_full &&
                    req_addr[23:20] == REG_UART && req_addr[7:0] == UART_TX_OFS;
  assign exp_rd   = rd_acc && req_addr[23:20] == REG_UART &&
                    req_addr[7:0] == UART_RXDATA_OFS;

  assert property (@(posedge clk) disable iff (rst) rd_acc |=> rsp_valid)
    else begin
      errors++;
      $display("%s: no response one cycle after a read", test_name);
    end
  assert property (@(posedge clk) disable iff (rst) !rd_acc |=> !rsp_valid)
    else begin
      errors++;
      $display("%s: response without an accepted read", test_name);
    end
  assert property (@(posedge clk) disable iff (rst)
                   rsp_valid |-> (rsp_rdata == exp_rdata && rsp_fault == exp_fault))
    else begin
      errors++;
      $display("Mismatch %s: expected %h fault %b, actual %h fault %b",
               test_name, exp_rdata, exp_fault, rsp_rdata, rsp_fault);
    end
  assert property (@(posedge clk) disable iff (rst) uart_trmt == exp_trmt)
    else begin
      errors++;
      $display("%s: uart_trmt pulse at the wrong cycle", test_name);
    end
  assert property (@(posedge clk) disable iff (rst)
                   uart_trmt |-> uart_tx_data == req_wdata[7:0])
    else begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", test_name, req_wdata[7:0], uart_tx_data);
    end
  assert property (@(posedge clk) disable iff (rst) uart_rd == exp_rd)
    else begin
      errors++;
      $display("%s: uart_rd pulse at the wrong cycle", test_name);
    end

  // watchdog, 1.5x the summed test lengths
  initial begin
    #(TEST_CYCLES * 15);
    $display("watchdog expired, the run did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////

  function automatic logic is_mapped(input word_t addr);
    region_e r;
    r = region_e'(addr[23:20]);
    return r inside {REG_INST, REG_DATA_LO, REG_DATA_HI, REG_UART, REG_RESULT};
  endfunction

  task automatic wait_accept();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!req_ready && n < ACCEPT_LIMIT);
    #1;
    acc_cyc = cyc;
    if (n >= ACCEPT_LIMIT) begin
      errors++;
      $display("%s: request never accepted", test_name);
    end
  endtask

  task automatic cpu_write(input word_t addr, input word_t data, input logic is_byte);
    word_t w;
    int key;
    req_valid = 1'b1;
    req_write = 1'b1;
    req_byte  = is_byte;
    req_addr  = addr;
    req_wdata = data;
    wait_accept();
    req_valid = 1'b0;
    req_write = 1'b0;
    key = addr & 32'hfffffffc;
    if (addr[23:20] inside {REG_DATA_LO, REG_DATA_HI}) begin
      w = dmem_m.exists(key) ? dmem_m[key] : '0;
      if (is_byte) w[addr[1:0]*8 +: 8] = data[7:0];
      else w = data;
      dmem_m[key] = w;
    end else if (addr[23:20] == REG_INST && !is_byte) begin
      imem_m[key] = data;
    end
  endtask

  task automatic cpu_read(input word_t addr, input logic is_byte, input word_t exp);
    exp_rdata = is_mapped(addr) ? exp : '0;
    exp_fault = !is_mapped(addr);
    req_valid = 1'b1;
    req_write = 1'b0;
    req_byte  = is_byte;
    req_addr  = addr;
    wait_accept();
    req_valid = 1'b0;
    @(posedge clk);  // response edge
    #1;
  endtask

  task automatic spu_write(input logic [3:0] a, input word_t d);
    spu_res_we   = 1'b1;
    spu_res_addr = a;
    spu_res_data = d;
    @(posedge clk);
    #1;
    spu_res_we = 1'b0;
    res_m[int'(a)] = d;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_at_start) tests_failed++;
    $display("test %s: %s", test_name, errors == err_at_start ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    word_t a, w, line [4];
    int t0;
    void'($urandom(32'hea153e4a));
    {req_valid, req_write, req_byte, spu_res_we} = '0;
    {req_addr, req_wdata, pc, spu_addr, spu_res_data} = '0;
    spu_res_addr = '0;
    {uart_tx_full, uart_rx_empty} = '0;
    uart_rx_data = '0;
    {errors, tests_run, tests_failed, acc_cyc} = '0;
    exp_rdata = '0;
    exp_fault = 1'b0;
    test_name = "reset";
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("data_mem");
    for (int i = 0; i < 8; i++) begin
      a = (($urandom & 1) ? 32'h0090_0000 : 32'h0080_0000) | ($urandom & 32'h1ffc);
      cpu_write(a, $urandom, 1'b0);
    end
    foreach (dmem_m[k]) cpu_read(k, 1'b0, dmem_m[k]);
    a = 32'h0080_0100;
    cpu_write(a, 32'h1111_1111, 1'b0);
    for (int l = 0; l < 4; l++) cpu_write(a + l, $urandom, 1'b1);
    cpu_read(a, 1'b0, dmem_m[a]);
    for (int l = 0; l < 4; l++) cpu_read(a + l, 1'b1, (dmem_m[a] >> (l * 8)) & 32'hff);
    cpu_write(32'h0080_0200, 32'haaaa_0008, 1'b0);  // same offset, both banks
    cpu_write(32'h0090_0200, 32'h5555_0009, 1'b0);
    cpu_read(32'h0080_0200, 1'b0, 32'haaaa_0008);
    cpu_read(32'h0090_0200, 1'b0, 32'h5555_0009);
    end_test();

    begin_test("spu_line");
    for (int i = 0; i < 4; i++) begin
      line[i] = $urandom;
      cpu_write(32'h0080_0340 + i * 4, line[i], 1'b0);
    end
    spu_addr = 32'h0080_0340;
    @(posedge clk);
    #1;
    assert (spu_rdata == {line[3], line[2], line[1], line[0]}) else begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", test_name,
               {line[3], line[2], line[1], line[0]}, spu_rdata);
    end
    end_test();

    begin_test("inst_mem");
    w = $urandom;
    cpu_write(32'h0000_0024, w, 1'b0);
    pc = 32'h0000_0024;
    @(posedge clk);
    #1;
    assert (instr == w) else begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", test_name, w, instr);
    end
    cpu_read(32'h0000_0024, 1'b0, w);
    end_test();

    begin_test("result_regs");
    for (int r = 0; r < 5; r++) spu_write(4'(r), $urandom);
    for (int r = 0; r < 5; r++) cpu_read(32'h00b0_0000 + r * 4, 1'b0, res_m[r]);
    assert (disp_0 == res_m[0] && disp_1 == res_m[1] && disp_2 == res_m[2]) else begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", test_name,
               {res_m[0], res_m[1], res_m[2]}, {disp_0, disp_1, disp_2});
    end
    cpu_write(32'h00b0_0000 | CNT_LO_OFS, '0, 1'b0);
    t0 = acc_cyc;
    repeat (7) @(posedge clk);
    #1;
    cpu_read(32'h00b0_0000 | CNT_LO_OFS, 1'b0, cyc - t0);  // accepted at the next edge
    cpu_read(32'h00b0_0000 | CNT_HI_OFS, 1'b0, '0);
    end_test();

    begin_test("uart");
    cpu_write(32'h00a0_0000 | UART_TX_OFS, 32'h0000_005a, 1'b0);
    uart_tx_full = 1'b1;
    fork
      cpu_write(32'h00a0_0000 | UART_TX_OFS, 32'h0000_00c3, 1'b0);
      begin
        repeat (4) begin
          @(posedge clk);
          assert (!req_ready) else begin
            errors++;
            $display("%s: req_ready high while the tx buffer is full", test_name);
          end
        end
        #1;
        uart_tx_full = 1'b0;
      end
    join
    uart_tx_full = 1'b1;
    cpu_read(32'h00a0_0000 | UART_TXFULL_OFS, 1'b0, 32'd1);
    uart_tx_full = 1'b0;
    cpu_read(32'h00a0_0000 | UART_TXFULL_OFS, 1'b0, 32'd0);
    uart_rx_empty = 1'b1;
    cpu_read(32'h00a0_0000 | UART_RXEMPTY_OFS, 1'b0, 32'd1);
    uart_rx_empty = 1'b0;
    uart_rx_data = 8'($urandom);
    cpu_read(32'h00a0_0000 | UART_RXDATA_OFS, 1'b0, {24'd0, uart_rx_data});
    end_test();

    begin_test("fault");
    cpu_read(32'h0030_0010, 1'b0, '0);
    cpu_write(32'h0020_0200, 32'hdead_beef, 1'b0);  // low bits alias a data word
    cpu_write(32'h0030_0024, 32'hdead_beef, 1'b0);  // low bits alias the program word
    foreach (dmem_m[k]) cpu_read(k, 1'b0, dmem_m[k]);
    foreach (imem_m[k]) cpu_read(k, 1'b0, imem_m[k]);
    foreach (res_m[k]) cpu_read(32'h00b0_0000 + k * 4, 1'b0, res_m[k]);
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/bus_pkg.sv
source/mem_map_pkg.sv
source/periph_if.sv
source/inst_mem.sv
source/data_mem.sv
source/result_regs.sv
source/uart_port.sv
source/mem_router.sv
source/mmu_top.sv
sim/mmu_tb.sv

//--- Makefile
# Verilator flow for the memory-management hub

TB_TOP := mmu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module mmu_top
	verilator --lint-only --timing --assert -f flist.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
